// ==== Makefile ====
# Verilator build and run for the ROM download router

VERILATOR  ?= verilator
TOP        ?= tb_rom_loader
RTL_TOP    ?= rom_loader_top
FILELIST   ?= rom_loader.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/cfg_store.sv ====
// board configuration register file
// written by index from the header, combinational read port
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module cfg_store (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_we,
    input  logic [4:0] cfg_idx,
    input  logic [7:0] cfg_data,
    input  logic [4:0] cfg_raddr,
    output logic [7:0] cfg_rdata
);

    localparam logic [4:0] NREGS = 5'(`CFG_REGSIZE);

    logic [7:0] regs [0:`CFG_REGSIZE-1];  // one byte per board register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CFG_REGSIZE; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (cfg_we) begin
            regs[cfg_idx] <= cfg_data;
        end
    end

    // out of range reads give zero
    assign cfg_rdata = (cfg_raddr < NREGS) ? regs[cfg_raddr] : 8'h00;

    // header decode must keep the index inside the file
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_we |-> cfg_idx < NREGS);

endmodule

// ==== design/header_capture.sv ====
// input side of the ROM router
// accept strobe, start table shift register, configuration byte routing
// and decrypt flag latch
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module header_capture import rom_loader_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         downloading,
    input  logic         ioctl_wr,
    input  logic         ioctl_wait,
    input  logic [24:0]  ioctl_addr,
    input  logic [7:0]   ioctl_data,
    output start_table_u starts,
    output logic         decrypt,
    output logic         swap_bit,
    output logic         cfg_we,
    output logic [4:0]   cfg_idx,
    output logic [7:0]   cfg_data,
    output logic         accept,
    output logic         in_bulk
);

    localparam logic [24:0] START_END = 25'(`START_BYTES);
    localparam logic [24:0] CFG_FIRST = 25'(2 * `START_BYTES); // table padded to 16
    localparam logic [24:0] CFG_END   = CFG_FIRST + 25'(`CFG_REGSIZE);
    localparam logic [24:0] FLAG_ADDR = 25'(`CFG_BYTE);
    localparam logic [24:0] HDR_END   = 25'(`HEADER_BYTES);

    logic is_start;     // start table bytes
    logic is_cfg;       // config block, bytes 8..15 reserved
    logic bulk_seen;    // a bulk byte went through this download

    assign accept   = downloading && ioctl_wr && !ioctl_wait; // host handshake
    assign is_start = ioctl_addr < START_END;
    assign is_cfg   = ioctl_addr >= CFG_FIRST && ioctl_addr < CFG_END;
    assign in_bulk  = accept && ioctl_addr >= HDR_END;        // sole header range test

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            starts    <= '0;
            decrypt   <= 1'b0;
            swap_bit  <= 1'b0;
            bulk_seen <= 1'b0;
        end else if (!downloading) begin
            decrypt   <= 1'b0;  // flags live for one download only
            swap_bit  <= 1'b0;
            bulk_seen <= 1'b0;
        end else if (accept) begin
            if (is_start)
                starts.bytes <= {ioctl_data, starts.bytes[7:1]}; // little-endian
            if (ioctl_addr == FLAG_ADDR)
                {decrypt, swap_bit} <= ioctl_data[7:6];
            if (in_bulk)
                bulk_seen <= 1'b1;
        end
    end

    // config write trails the accept by one edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cfg_we <= 1'b0;
        else
            cfg_we <= accept && is_cfg;
    end

    always_ff @(posedge clk) begin
        cfg_idx  <= ioctl_addr[4:0] - CFG_FIRST[4:0]; // window < 32, wraps cleanly
        cfg_data <= ioctl_data;
    end

    // once bulk data flows the region map must not move under it
    a_table_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        bulk_seen |-> $stable(starts));

endmodule

// ==== design/region_map.sv ====
// processing stage of the ROM router
// region decode from the start table, SDRAM address translation,
// lane mask, bank select and CPU byte descrambling, one register stage
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module region_map import rom_loader_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                accept,
    input  logic                in_bulk,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  start_table_u        starts,
    input  logic                decrypt,
    input  logic                swap_bit,
    output logic                map_valid,
    output logic [21:0]         map_addr,
    output logic [7:0]          map_data,
    output logic [1:0]          map_mask,
    output logic [1:0]          map_bank,
    output logic                map_is_prom,
    output logic [`PROM_AW-1:0] prom_addr_next
);

    localparam logic [24:0] HDR_LEN = 25'(`HEADER_BYTES);

    logic [24:0] bulk_off;     // byte offset past the header
    logic [15:0] off_kb;       // same, in kB
    logic [4:0]  hits;         // per-region match, one-hot when table is sane
    region_e     region;
    logic [15:0] base_kb;      // region start
    logic [21:0] dest_off;     // SDRAM word offset of region
    logic [24:0] region_off;   // byte offset inside region
    logic        crypt;        // this byte needs descrambling
    logic [7:0]  plain;        // descrambled byte

    assign bulk_off = ioctl_addr - HDR_LEN;
    assign off_kb   = {1'b0, bulk_off[24:10]};

    assign hits[0] = off_kb < starts.kb.snd_start;
    assign hits[1] = off_kb >= starts.kb.snd_start && off_kb < starts.kb.pcm_start;
    assign hits[2] = off_kb >= starts.kb.pcm_start && off_kb < starts.kb.gfx_start;
    assign hits[3] = off_kb >= starts.kb.gfx_start && off_kb < starts.kb.qsnd_start;
    assign hits[4] = off_kb >= starts.kb.qsnd_start;

    always_comb begin
        if (hits[0])      region = reg_cpu;   // first match wins
        else if (hits[1]) region = reg_snd;
        else if (hits[2]) region = reg_pcm;
        else if (hits[3]) region = reg_gfx;
        else              region = reg_qsnd;
    end

    always_comb begin
        case (region)
            reg_snd:  begin base_kb = starts.kb.snd_start;  dest_off = `SND_OFFSET; end
            reg_pcm:  begin base_kb = starts.kb.pcm_start;  dest_off = `PCM_OFFSET; end
            reg_gfx:  begin base_kb = starts.kb.gfx_start;  dest_off = `GFX_OFFSET; end
            reg_qsnd: begin base_kb = starts.kb.qsnd_start; dest_off = 22'h0;       end
            default:  begin base_kb = 16'h0;                dest_off = `CPU_OFFSET; end
        endcase
    end

    assign region_off = bulk_off - {base_kb[14:0], 10'd0};

    // upper half of the CPU program, one byte lane per swap setting
    assign crypt = region == reg_cpu && bulk_off[19] && decrypt
                   && (bulk_off[0] ^ swap_bit);

    // bit permutation folded into xor terms
    assign plain = ({8{ ioctl_data[0]}} & 8'h04)
                 ^ ({8{ ioctl_data[1]}} & 8'h21)
                 ^ ({8{ ioctl_data[2]}} & 8'h01)
                 ^ ({8{~ioctl_data[3]}} & 8'h50)
                 ^ ({8{ ioctl_data[4]}} & 8'h40)
                 ^ ({8{ ioctl_data[5]}} & 8'h06)
                 ^ ({8{ ioctl_data[6]}} & 8'h08)
                 ^ ({8{~ioctl_data[7]}} & 8'h88);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            map_valid <= 1'b0;
        else
            map_valid <= in_bulk;   // header bytes never leave this stage
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            map_addr       <= region_off[22:1] + dest_off;   // 16-bit words
            map_data       <= crypt ? plain : ioctl_data;
            map_mask       <= ioctl_addr[0] ? 2'b01 : 2'b10; // active low lanes
            map_bank       <= region == reg_cpu ? 2'b01 :
                              region == reg_gfx ? 2'b10 : 2'b00;
            map_is_prom    <= region == reg_qsnd;
            prom_addr_next <= region_off[`PROM_AW-1:0];      // PROM is byte wide
        end
    end

    // a broken start table would route a byte nowhere or twice
    a_one_region: assert property (@(posedge clk) disable iff (!rst_n)
        map_valid |-> $onehot($past(hits)));

endmodule

// ==== design/rom_loader_pkg.sv ====
// types shared by the ROM download router
// start table union and region enumeration

package rom_loader_pkg;

    // start table, 8 header bytes
    // shifted in byte by byte, read back as four kB starts
    typedef union packed {
        logic [7:0][7:0] bytes;        // bytes[0] is header byte 0
        struct packed {
            logic [15:0] qsnd_start;   // header bytes 6,7
            logic [15:0] gfx_start;    // header bytes 4,5
            logic [15:0] pcm_start;    // header bytes 2,3
            logic [15:0] snd_start;    // header bytes 0,1
        } kb;
    } start_table_u;

    // bulk data regions in download order
    typedef enum logic [2:0] {
        reg_cpu,                       // main CPU program
        reg_snd,                       // sound CPU program
        reg_pcm,                       // OKI samples
        reg_gfx,                       // tiles and sprites
        reg_qsnd                       // Q-Sound PROM, not in SDRAM
    } region_e;

endpackage

// ==== design/rom_loader_settings.svh ====
// header layout, configuration block size and SDRAM region offsets
// for the ROM download router
`ifndef ROM_LOADER_SETTINGS_SVH
`define ROM_LOADER_SETTINGS_SVH

// download header
`define HEADER_BYTES 64         // full header, bulk data starts past it
`define START_BYTES  8          // four 16-bit region starts, kB units
`define CFG_REGSIZE  24         // board configuration bytes
`define CFG_BYTE     39         // flag byte, bit7 decrypt, bit6 swap

// SDRAM word offsets per region
`define CPU_OFFSET   22'h000000
`define SND_OFFSET   22'h100000
`define PCM_OFFSET   22'h140000
`define GFX_OFFSET   22'h200000

// Q-Sound internal PROM
`define PROM_AW      13         // byte address width

`endif

// ==== design/rom_loader_top.sv ====
// top level of the ROM download router
// header capture, config store, region map and SDRAM write port
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module rom_loader_top import rom_loader_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    // host ioctl port
    input  logic                downloading,
    input  logic                ioctl_wr,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    output logic                ioctl_wait,
    // SDRAM programming port
    output logic [21:0]         prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,   // active low
    output logic [1:0]          prog_bank,
    output logic                prog_we,
    input  logic                sdram_ack,
    // Q-Sound PROM
    output logic [`PROM_AW-1:0] prom_addr,
    output logic [7:0]          prom_data,
    output logic                prom_we,
    // board config readback
    input  logic [4:0]          cfg_raddr,
    output logic [7:0]          cfg_rdata
);

    start_table_u       starts;
    logic               decrypt, swap_bit;
    logic               cfg_we;
    logic [4:0]         cfg_idx;
    logic [7:0]         cfg_data;
    logic               accept, in_bulk;
    logic               map_valid, map_is_prom;
    logic [21:0]        map_addr;
    logic [7:0]         map_data;
    logic [1:0]         map_mask, map_bank;
    logic [`PROM_AW-1:0] prom_addr_next;

    header_capture u_hdr (
        .clk, .rst_n, .downloading, .ioctl_wr, .ioctl_wait,
        .ioctl_addr, .ioctl_data, .starts, .decrypt, .swap_bit,
        .cfg_we, .cfg_idx, .cfg_data, .accept, .in_bulk
    );

    cfg_store u_cfg (
        .clk, .rst_n, .cfg_we, .cfg_idx, .cfg_data, .cfg_raddr, .cfg_rdata
    );

    region_map u_map (
        .clk, .rst_n, .accept, .in_bulk, .ioctl_addr, .ioctl_data,
        .starts, .decrypt, .swap_bit, .map_valid, .map_addr, .map_data,
        .map_mask, .map_bank, .map_is_prom, .prom_addr_next
    );

    sdram_write_port u_wr (
        .clk, .rst_n, .downloading, .accept, .in_bulk,
        .map_valid, .map_addr, .map_data, .map_mask, .map_bank, .map_is_prom,
        .prom_addr_next, .sdram_ack,
        .prog_addr, .prog_data, .prog_mask, .prog_bank, .prog_we,
        .prom_addr, .prom_data, .prom_we, .ioctl_wait
    );

endmodule

// ==== design/sdram_write_port.sv ====
// output side of the ROM router
// SDRAM write held until ack, PROM write pulse, host back-pressure
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module sdram_write_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic                accept,
    input  logic                in_bulk,
    input  logic                map_valid,
    input  logic [21:0]         map_addr,
    input  logic [7:0]          map_data,
    input  logic [1:0]          map_mask,
    input  logic [1:0]          map_bank,
    input  logic                map_is_prom,
    input  logic [`PROM_AW-1:0] prom_addr_next,
    input  logic                sdram_ack,
    output logic [21:0]         prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_bank,
    output logic                prog_we,
    output logic [`PROM_AW-1:0] prom_addr,
    output logic [7:0]          prom_data,
    output logic                prom_we,
    output logic                ioctl_wait
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we    <= 1'b0;
            prom_we    <= 1'b0;
            ioctl_wait <= 1'b0;
        end else if (!downloading) begin
            prog_we    <= 1'b0;   // abort pending write
            prom_we    <= 1'b0;
            ioctl_wait <= 1'b0;
        end else begin
            prom_we <= map_valid && map_is_prom;
            if (map_valid && !map_is_prom)
                prog_we <= 1'b1;
            else if (sdram_ack)
                prog_we <= 1'b0;
            // stall host until the byte has left
            if (accept && in_bulk)
                ioctl_wait <= 1'b1;
            else if ((prog_we && sdram_ack) || prom_we)
                ioctl_wait <= 1'b0;
        end
    end

    // fields only load on a new write, so they hold through the wait
    always_ff @(posedge clk) begin
        if (map_valid && !map_is_prom) begin
            prog_addr <= map_addr;
            prog_data <= map_data;
            prog_mask <= map_mask;
            prog_bank <= map_bank;
        end
        if (map_valid && map_is_prom) begin
            prom_addr <= prom_addr_next;
            prom_data <= map_data;
        end
    end

    a_prog_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !sdram_ack && downloading |=>
            prog_we && $stable({prog_addr, prog_data, prog_mask, prog_bank}));

endmodule

// ==== rom_loader.f ====
+incdir+design
design/rom_loader_pkg.sv
design/header_capture.sv
design/cfg_store.sv
design/region_map.sv
design/sdram_write_port.sv
design/rom_loader_top.sv
test/tb_rom_loader.sv

// ==== test/tb_rom_loader.sv ====
// testbench for the ROM download router
// clock, reset, watchdog, SDRAM responder, write monitor,
// reference model and directed tests
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module tb_rom_loader;

    localparam int SND_KB    = 1024;   // region starts of the test image
    localparam int PCM_KB    = 1280;
    localparam int GFX_KB    = 1536;
    localparam int QSND_KB   = 2048;
    localparam int CFG_FIRST = 16;     // config block after the padded start table
    localparam int BP_BYTES  = 40;
    localparam int TOTAL_BYTES = 6 * `HEADER_BYTES + 15 + 24 + BP_BYTES + 4;

    logic                clk, rst_n, downloading, ioctl_wr, ioctl_wait;
    logic [24:0]         ioctl_addr;
    logic [7:0]          ioctl_data, prog_data, prom_data, cfg_rdata;
    logic [21:0]         prog_addr;
    logic [1:0]          prog_mask, prog_bank;
    logic                prog_we, sdram_ack, prom_we;
    logic [`PROM_AW-1:0] prom_addr;
    logic [4:0]          cfg_raddr;

    logic [34:0] expect_q [$];         // {is_prom, addr, data, mask, bank}
    logic [7:0]  cfg_expect [0:`CFG_REGSIZE-1];
    logic [31:0] stim_rnd, ack_rnd;
    logic        hold_ack, cur_dec, cur_swp;
    logic        held = 1'b0;          // write pending at last negedge
    logic [33:0] held_fields;
    int          mismatches = 0;
    int          failures = 0;
    int          busy_cycles = 0;
    string       test_name = "reset";

    rom_loader_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (TOTAL_BYTES * 12 + 200) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;                            // inputs change just after the edge
    endtask

    // ack after 0..5 cycles, one pulse per write
    initial begin : sdram_responder
        int delay;
        sdram_ack = 1'b0;
        ack_rnd   = 32'h19d8;
        forever begin
            tick(1);
            if (prog_we && !hold_ack) begin
                ack_rnd = lcg_step(ack_rnd);
                delay   = int'(ack_rnd[23:16]) % 6;
                if (delay > 0)
                    tick(delay);
                sdram_ack = 1'b1;
                tick(1);
                sdram_ack = 1'b0;
            end
        end
    end

    function automatic logic [7:0] descramble(input logic [7:0] d);
        logic [63:0] terms;
        logic [7:0]  when_clear;
        logic [7:0]  r;
        terms      = {8'h88, 8'h08, 8'h06, 8'h40, 8'h50, 8'h01, 8'h21, 8'h04}; // bit7..bit0
        when_clear = 8'h88;            // bits 3 and 7 count when low
        r          = 8'h00;
        for (int i = 0; i < 8; i++)
            if (d[i] != when_clear[i])
                r = r ^ terms[i*8 +: 8];
        return r;
    endfunction

    // expected write for one bulk byte
    function automatic logic [34:0] expect_write(input logic [24:0] a, input logic [7:0] d);
        int          off;
        int          base;
        logic [21:0] dest;
        logic [1:0]  bank;
        logic [7:0]  data;
        off  = int'(a) - `HEADER_BYTES;
        data = d;
        bank = 2'b00;
        if (off / 1024 >= QSND_KB)
            return {1'b1, 9'd0, 13'(off - QSND_KB * 1024), d, 4'd0};
        if (off / 1024 >= GFX_KB) begin
            base = GFX_KB;
            dest = `GFX_OFFSET;
            bank = 2'b10;
        end else if (off / 1024 >= PCM_KB) begin
            base = PCM_KB;
            dest = `PCM_OFFSET;
        end else if (off / 1024 >= SND_KB) begin
            base = SND_KB;
            dest = `SND_OFFSET;
        end else begin
            base = 0;
            dest = `CPU_OFFSET;
            bank = 2'b01;
            if (cur_dec && off[19] && (off[0] != cur_swp))
                data = descramble(d);  // upper CPU half, one lane
        end
        return {1'b0, 22'((off - base * 1024) / 2) + dest, data, a[0] ? 2'b01 : 2'b10, bank};
    endfunction

    function automatic void check_write(input logic [34:0] got);
        logic [34:0] want;
        if (expect_q.size() == 0) begin
            failures++;
            $display("%s: write %h appeared with no byte pending", test_name, got);
        end else begin
            want = expect_q.pop_front();
            if (got !== want) begin
                mismatches++;
                $display("MISMATCH %s: expected %h, actual %h", test_name, want, got);
            end
        end
    endfunction

    // retired writes and SDRAM hold checks, mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (prog_we || prom_we)
                busy_cycles++;
            if (held && (!prog_we || {prog_addr, prog_data, prog_mask, prog_bank} != held_fields)) begin
                failures++;
                $display("%s: SDRAM write dropped or changed before sdram_ack", test_name);
            end
            held        = prog_we && !sdram_ack && downloading;
            held_fields = {prog_addr, prog_data, prog_mask, prog_bank};
            if (prog_we && sdram_ack)
                check_write({1'b0, prog_addr, prog_data, prog_mask, prog_bank});
            if (prom_we)
                check_write({1'b1, 9'd0, prom_addr, prom_data, 4'd0});
        end
    end

    // hold the byte until the edge that accepts it
    task automatic send_byte(input logic [24:0] a, input logic [7:0] d);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        while (ioctl_wait)
            tick(1);
        tick(1);                       // accept edge
        ioctl_wr = 1'b0;
    endtask

    task automatic send_bulk(input int off);
        logic [24:0] a;
        logic [7:0]  d;
        stim_rnd = lcg_step(stim_rnd);
        d        = stim_rnd[23:16];
        a        = 25'(off + `HEADER_BYTES);
        expect_q.push_back(expect_write(a, d));
        send_byte(a, d);
    endtask

    task automatic send_header(input logic dec, input logic swp);
        logic [63:0] table_bytes;
        logic [7:0]  d;
        table_bytes = {16'(QSND_KB), 16'(GFX_KB), 16'(PCM_KB), 16'(SND_KB)};
        for (int i = 0; i < `HEADER_BYTES; i++) begin
            if (i < `START_BYTES)
                d = table_bytes[i*8 +: 8];
            else if (i == `CFG_BYTE)
                d = {dec, swp, 6'h15};
            else
                d = 8'(i * 29 + 3);
            if (i >= CFG_FIRST && i < CFG_FIRST + `CFG_REGSIZE)
                cfg_expect[i - CFG_FIRST] = d;
            send_byte(25'(i), d);
        end
        cur_dec = dec;
        cur_swp = swp;
    endtask

    task automatic restart_download();
        downloading = 1'b0;
        tick(2);
        downloading = 1'b1;
        tick(1);
    endtask

    task automatic drain();
        while (expect_q.size() != 0)
            tick(1);
        tick(2);
    endtask

    task automatic test_header();
        int busy_before;
        test_name = "header";
        restart_download();
        busy_before = busy_cycles;
        send_header(1'b0, 1'b0);
        tick(3);
        if (busy_cycles != busy_before) begin
            failures++;
            $display("header: an SDRAM or PROM write happened during the header");
        end
        for (int i = 0; i < `CFG_REGSIZE; i++) begin
            cfg_raddr = 5'(i);
            tick(1);
            if (cfg_rdata !== cfg_expect[i]) begin
                mismatches++;
                $display("MISMATCH %s cfg %0d: expected %h, actual %h",
                         test_name, i, cfg_expect[i], cfg_rdata);
            end
        end
    endtask

    task automatic test_routing();
        int starts_kb [4];
        test_name = "routing";
        starts_kb = '{SND_KB, PCM_KB, GFX_KB, QSND_KB};
        send_bulk(0);
        send_bulk(1);
        foreach (starts_kb[i]) begin
            send_bulk(starts_kb[i] * 1024 - 1);  // last byte below the boundary
            send_bulk(starts_kb[i] * 1024);
            send_bulk(starts_kb[i] * 1024 + 3);
        end
        send_bulk(QSND_KB * 1024 + 8191);        // top of the PROM
        drain();
    endtask

    task automatic test_decrypt();
        test_name = "decrypt";
        for (int m = 0; m < 4; m++) begin
            restart_download();
            send_header(m[1], m[0]);
            send_bulk(32'h100);
            send_bulk(32'h101);
            send_bulk(32'h80000);
            send_bulk(32'h80001);
            send_bulk(32'h9fffe);
            send_bulk(32'h9ffff);
            drain();
        end
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        for (int i = 0; i < BP_BYTES; i++) begin
            stim_rnd = lcg_step(stim_rnd);
            send_bulk(int'(stim_rnd % ((QSND_KB + 8) * 1024)));
        end
        drain();
    endtask

    task automatic test_latency_abort();
        test_name = "latency";
        restart_download();
        send_header(1'b1, 1'b0);
        send_bulk(32'h80001);          // returns just after the accept edge
        if (prog_we !== 1'b0) begin
            failures++;
            $display("latency: prog_we rose one cycle after the accept");
        end
        tick(1);
        if (prog_we !== 1'b1) begin
            failures++;
            $display("latency: prog_we not high two cycles after the accept");
        end
        drain();
        test_name = "abort";
        hold_ack  = 1'b1;              // keep the next write pending
        send_byte(25'(`HEADER_BYTES + 32'h80001), 8'h5a);
        tick(2);
        if (prog_we !== 1'b1) begin
            failures++;
            $display("abort: SDRAM write not pending before downloading fell");
        end
        downloading = 1'b0;
        tick(1);
        if (prog_we !== 1'b0 || ioctl_wait !== 1'b0) begin
            failures++;
            $display("abort: pending write or wait not cleared when downloading fell");
        end
        hold_ack    = 1'b0;
        downloading = 1'b1;
        tick(1);
        cur_dec = 1'b0;                // flags dropped with the download
        cur_swp = 1'b0;
        send_bulk(32'h80001);
        send_bulk(32'h80000);
        drain();
    endtask

    initial begin
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        cfg_raddr   = '0;
        hold_ack    = 1'b0;
        cur_dec     = 1'b0;
        cur_swp     = 1'b0;
        stim_rnd    = 32'h19d8;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick(1);
        if (prog_we !== 1'b0 || prom_we !== 1'b0 || ioctl_wait !== 1'b0) begin
            failures++;
            $display("reset: write strobes or ioctl_wait not low after reset");
        end
        test_header();
        test_routing();
        test_decrypt();
        test_backpressure();
        test_latency_abort();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
